// File: design/axi_arbiter.sv
`timescale 1ns/1ps

module axi_arbiter #(
  parameter int LINE_WORDS = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  // icache read link
  input  logic              i_ar_valid,
  input  cpu_if_pkg::addr_t i_ar_addr,
  input  logic [7:0]        i_ar_len,
  output logic              i_ar_ready,
  output logic              i_r_valid,
  output cpu_if_pkg::word_t i_r_data,
  output logic              i_r_last,
  // data port read link
  input  logic              d_ar_valid,
  input  cpu_if_pkg::addr_t d_ar_addr,
  input  logic [7:0]        d_ar_len,
  output logic              d_ar_ready,
  output logic              d_r_valid,
  output cpu_if_pkg::word_t d_r_data,
  output logic              d_r_last,
  // data port write link
  input  logic              w_req,
  input  cpu_if_pkg::addr_t w_addr,
  input  cpu_if_pkg::word_t w_data,
  input  logic [3:0]        w_strb,
  output logic              w_ack,
  output logic              b_done,
  // axi master
  output axi_pkg::axi_id_e  arid,
  output cpu_if_pkg::addr_t araddr,
  output logic [7:0]        arlen,
  output logic              arvalid,
  input  logic              arready,
  input  logic [3:0]        rid,
  input  cpu_if_pkg::word_t rdata,
  input  logic              rlast,
  input  logic              rvalid,
  output logic              rready,
  output cpu_if_pkg::addr_t awaddr,
  output logic              awvalid,
  input  logic              awready,
  output cpu_if_pkg::word_t wdata,
  output logic [3:0]        wstrb,
  output logic              wlast,
  output logic              wvalid,
  input  logic              wready,
  input  logic              bvalid,
  output logic              bready
);

  axi_pkg::arb_state_e state;
  axi_pkg::axi_id_e    owner;
  logic                r_beat;
  logic                wr_busy;

  // address and length come straight from the granted link
  assign arid       = owner;
  assign arvalid    = (state == axi_pkg::ARB_ADDR);
  assign araddr     = (owner == axi_pkg::ID_INST) ? i_ar_addr : d_ar_addr;
  assign arlen      = (owner == axi_pkg::ID_INST) ? i_ar_len : d_ar_len;
  assign i_ar_ready = arvalid && arready && (owner == axi_pkg::ID_INST);
  assign d_ar_ready = arvalid && arready && (owner == axi_pkg::ID_DATA);

  assign rready    = (state == axi_pkg::ARB_DATA);
  assign r_beat    = rvalid && rready;
  assign i_r_valid = r_beat && (rid == axi_pkg::ID_INST);
  assign d_r_valid = r_beat && (rid == axi_pkg::ID_DATA);
  assign i_r_data  = rdata;
  assign d_r_data  = rdata;
  assign i_r_last  = rlast;
  assign d_r_last  = rlast;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= axi_pkg::ARB_IDLE;
      owner <= axi_pkg::ID_DATA;
    end else begin
      case (state)
        axi_pkg::ARB_IDLE: begin
          if (i_ar_valid || d_ar_valid) begin
            state <= axi_pkg::ARB_ADDR;
            // round robin where the previous owner yields on a tie
            if (i_ar_valid && (!d_ar_valid || owner == axi_pkg::ID_DATA)) begin
              owner <= axi_pkg::ID_INST;
            end else begin
              owner <= axi_pkg::ID_DATA;
            end
          end
        end
        axi_pkg::ARB_ADDR: begin
          if (arready) begin
            state <= axi_pkg::ARB_DATA;
          end
        end
        axi_pkg::ARB_DATA: begin
          if (r_beat && rlast) begin
            state <= axi_pkg::ARB_IDLE;
          end
        end
        default: begin
          state <= axi_pkg::ARB_IDLE;
        end
      endcase
    end
  end

  // single-beat write tracker
  assign awaddr = w_addr;
  assign wdata  = w_data;
  assign wstrb  = w_strb;
  assign wlast  = 1'b1;
  // pulses in the cycle the later of AW and W completes
  assign w_ack  = (awvalid || wvalid) && (!awvalid || awready) && (!wvalid || wready);
  assign b_done = bvalid && bready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_busy <= 1'b0;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b0;
    end else begin
      if (w_req && !wr_busy) begin
        wr_busy <= 1'b1;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
      end
      if (awvalid && awready) begin
        awvalid <= 1'b0;
      end
      if (wvalid && wready) begin
        wvalid <= 1'b0;
      end
      if (w_ack) begin
        bready <= 1'b1;
      end
      if (b_done) begin
        bready  <= 1'b0;
        wr_busy <= 1'b0;
      end
    end
  end

  a_rid_owner: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid |-> (state == axi_pkg::ARB_DATA) && (rid == owner));

  a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (arvalid && !arready) |=> arvalid && $stable(araddr) && $stable(arlen) && $stable(arid));

  a_arlen_line: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid |-> (arlen < LINE_WORDS));

endmodule

// File: design/axi_pkg.sv
package axi_pkg;

  localparam int ID_W = 4;

  // arid / rid per requester
  typedef enum logic [ID_W-1:0] {
    ID_INST = 4'd0,
    ID_DATA = 4'd1
  } axi_id_e;

  // icache controller
  typedef enum logic [1:0] {
    IC_IDLE,
    IC_MISS_ADDR,
    IC_MISS_DATA,
    IC_RESP
  } ic_state_e;

  // read channel owner tracking
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_ADDR,
    ARB_DATA
  } arb_state_e;

endpackage

// File: design/cpu_if_pkg.sv
package cpu_if_pkg;

  // sram-like port widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] word_t;

  // access size coded as in the size field of the sram-like bus
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } size_e;

endpackage

// File: design/cpu_mem_top.sv
`timescale 1ns/1ps

module cpu_mem_top #(
  parameter int LINE_WORDS = 4,
  parameter int SETS       = 16
) (
  input  logic              clk,
  input  logic              rst_n,
  // instruction port
  input  logic              inst_req,
  input  logic              inst_cached,
  input  cpu_if_pkg::addr_t inst_addr,
  output logic              inst_addr_ok,
  output logic              inst_data_ok,
  output cpu_if_pkg::word_t inst_rdata,
  // data port
  input  logic              data_req,
  input  logic              data_wr,
  input  cpu_if_pkg::size_e data_size,
  input  cpu_if_pkg::addr_t data_addr,
  input  cpu_if_pkg::word_t data_wdata,
  output logic              data_addr_ok,
  output logic              data_data_ok,
  output cpu_if_pkg::word_t data_rdata,
  // axi master
  output axi_pkg::axi_id_e  arid,
  output cpu_if_pkg::addr_t araddr,
  output logic [7:0]        arlen,
  output logic              arvalid,
  input  logic              arready,
  input  logic [3:0]        rid,
  input  cpu_if_pkg::word_t rdata,
  input  logic              rlast,
  input  logic              rvalid,
  output logic              rready,
  output cpu_if_pkg::addr_t awaddr,
  output logic              awvalid,
  input  logic              awready,
  output cpu_if_pkg::word_t wdata,
  output logic [3:0]        wstrb,
  output logic              wlast,
  output logic              wvalid,
  input  logic              wready,
  input  logic              bvalid,
  output logic              bready
);

  logic              i_ar_valid;
  cpu_if_pkg::addr_t i_ar_addr;
  logic [7:0]        i_ar_len;
  logic              i_ar_ready;
  logic              i_r_valid;
  cpu_if_pkg::word_t i_r_data;
  logic              i_r_last;

  logic              d_ar_valid;
  cpu_if_pkg::addr_t d_ar_addr;
  logic [7:0]        d_ar_len;
  logic              d_ar_ready;
  logic              d_r_valid;
  cpu_if_pkg::word_t d_r_data;
  logic              d_r_last;

  logic              w_req;
  cpu_if_pkg::addr_t w_addr;
  cpu_if_pkg::word_t w_data;
  logic [3:0]        w_strb;
  logic              w_ack;
  logic              b_done;

  icache #(
    .LINE_WORDS (LINE_WORDS),
    .SETS       (SETS)
  ) i_icache (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (inst_req),
    .cached   (inst_cached),
    .addr     (inst_addr),
    .addr_ok  (inst_addr_ok),
    .data_ok  (inst_data_ok),
    .rdata    (inst_rdata),
    .ar_valid (i_ar_valid),
    .ar_addr  (i_ar_addr),
    .ar_len   (i_ar_len),
    .ar_ready (i_ar_ready),
    .r_valid  (i_r_valid),
    .r_data   (i_r_data),
    .r_last   (i_r_last)
  );

  data_port i_data_port (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (data_req),
    .wr       (data_wr),
    .size     (data_size),
    .addr     (data_addr),
    .wdata    (data_wdata),
    .addr_ok  (data_addr_ok),
    .data_ok  (data_data_ok),
    .rdata    (data_rdata),
    .ar_valid (d_ar_valid),
    .ar_addr  (d_ar_addr),
    .ar_len   (d_ar_len),
    .ar_ready (d_ar_ready),
    .r_valid  (d_r_valid),
    .r_data   (d_r_data),
    .r_last   (d_r_last),
    .w_req    (w_req),
    .w_addr   (w_addr),
    .w_data   (w_data),
    .w_strb   (w_strb),
    .w_ack    (w_ack),
    .b_done   (b_done)
  );

  axi_arbiter #(
    .LINE_WORDS (LINE_WORDS)
  ) i_axi_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_ar_valid (i_ar_valid),
    .i_ar_addr  (i_ar_addr),
    .i_ar_len   (i_ar_len),
    .i_ar_ready (i_ar_ready),
    .i_r_valid  (i_r_valid),
    .i_r_data   (i_r_data),
    .i_r_last   (i_r_last),
    .d_ar_valid (d_ar_valid),
    .d_ar_addr  (d_ar_addr),
    .d_ar_len   (d_ar_len),
    .d_ar_ready (d_ar_ready),
    .d_r_valid  (d_r_valid),
    .d_r_data   (d_r_data),
    .d_r_last   (d_r_last),
    .w_req      (w_req),
    .w_addr     (w_addr),
    .w_data     (w_data),
    .w_strb     (w_strb),
    .w_ack      (w_ack),
    .b_done     (b_done),
    .arid       (arid),
    .araddr     (araddr),
    .arlen      (arlen),
    .arvalid    (arvalid),
    .arready    (arready),
    .rid        (rid),
    .rdata      (rdata),
    .rlast      (rlast),
    .rvalid     (rvalid),
    .rready     (rready),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wlast      (wlast),
    .wvalid     (wvalid),
    .wready     (wready),
    .bvalid     (bvalid),
    .bready     (bready)
  );

endmodule

// File: design/data_port.sv
`timescale 1ns/1ps

module data_port (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req,
  input  logic              wr,
  input  cpu_if_pkg::size_e size,
  input  cpu_if_pkg::addr_t addr,
  input  cpu_if_pkg::word_t wdata,
  output logic              addr_ok,
  output logic              data_ok,
  output cpu_if_pkg::word_t rdata,
  output logic              ar_valid,
  output cpu_if_pkg::addr_t ar_addr,
  output logic [7:0]        ar_len,
  input  logic              ar_ready,
  input  logic              r_valid,
  input  cpu_if_pkg::word_t r_data,
  input  logic              r_last,
  output logic              w_req,
  output cpu_if_pkg::addr_t w_addr,
  output cpu_if_pkg::word_t w_data,
  output logic [3:0]        w_strb,
  input  logic              w_ack,
  input  logic              b_done
);

  logic              busy;
  logic              wr_q;
  cpu_if_pkg::size_e size_q;
  cpu_if_pkg::addr_t addr_q;
  cpu_if_pkg::word_t wdata_q;

  assign addr_ok = !busy;
  // loads end on the single read beat, stores on the write response
  assign data_ok = busy && (wr_q ? b_done : (r_valid && r_last));
  assign rdata   = r_data;
  assign ar_addr = {addr_q[31:2], 2'b00};
  assign ar_len  = 8'd0;
  assign w_addr  = {addr_q[31:2], 2'b00};

  // byte lanes from size and low address bits
  always_comb begin
    case (size_q)
      cpu_if_pkg::SIZE_BYTE: begin
        w_strb = 4'b0001 << addr_q[1:0];
        w_data = wdata_q << {addr_q[1:0], 3'b000};
      end
      cpu_if_pkg::SIZE_HALF: begin
        w_strb = addr_q[1] ? 4'b1100 : 4'b0011;
        w_data = addr_q[1] ? {wdata_q[15:0], 16'h0000} : wdata_q;
      end
      default: begin
        w_strb = 4'b1111;
        w_data = wdata_q;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      wr_q     <= 1'b0;
      ar_valid <= 1'b0;
      w_req    <= 1'b0;
    end else begin
      if (req && addr_ok) begin
        busy     <= 1'b1;
        wr_q     <= wr;
        ar_valid <= !wr;
        w_req    <= wr;
      end
      if (ar_valid && ar_ready) begin
        ar_valid <= 1'b0;
      end
      if (w_req && w_ack) begin
        w_req <= 1'b0;
      end
      if (data_ok) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req && addr_ok) begin
      size_q  <= size;
      addr_q  <= addr;
      wdata_q <= wdata;
    end
  end

  a_half_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    (req && addr_ok && size == cpu_if_pkg::SIZE_HALF) |-> !addr[0]);

endmodule

// File: design/icache.sv
`timescale 1ns/1ps

module icache #(
  parameter int LINE_WORDS = 4,
  parameter int SETS       = 16
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req,
  input  logic              cached,
  input  cpu_if_pkg::addr_t addr,
  output logic              addr_ok,
  output logic              data_ok,
  output cpu_if_pkg::word_t rdata,
  output logic              ar_valid,
  output cpu_if_pkg::addr_t ar_addr,
  output logic [7:0]        ar_len,
  input  logic              ar_ready,
  input  logic              r_valid,
  input  cpu_if_pkg::word_t r_data,
  input  logic              r_last
);

  localparam int OFF_W = $clog2(LINE_WORDS);
  localparam int IDX_W = $clog2(SETS);
  localparam int TAG_W = 30 - OFF_W - IDX_W;

  axi_pkg::ic_state_e state;

  logic              valid    [SETS];
  logic [TAG_W-1:0]  tag_mem  [SETS];
  cpu_if_pkg::word_t line_mem [SETS*LINE_WORDS];

  cpu_if_pkg::addr_t req_addr;
  logic              req_cached;
  logic [OFF_W-1:0]  beat_cnt;
  cpu_if_pkg::word_t rdata_q;

  logic [IDX_W-1:0]  in_idx;
  logic [TAG_W-1:0]  in_tag;
  logic [IDX_W-1:0]  fill_idx;
  logic [OFF_W-1:0]  fill_off;
  logic              hit;
  logic              fill_beat;

  // lookup indexes with the incoming address and the fill with the latched one
  assign in_idx    = addr[2+OFF_W +: IDX_W];
  assign in_tag    = addr[31 -: TAG_W];
  assign fill_idx  = req_addr[2+OFF_W +: IDX_W];
  assign fill_off  = req_addr[2 +: OFF_W];
  assign hit       = valid[in_idx] && (tag_mem[in_idx] == in_tag);
  assign fill_beat = (state == axi_pkg::IC_MISS_DATA) && r_valid;

  assign addr_ok  = (state == axi_pkg::IC_IDLE);
  assign data_ok  = (state == axi_pkg::IC_RESP);
  assign rdata    = rdata_q;
  assign ar_valid = (state == axi_pkg::IC_MISS_ADDR);
  // line-aligned burst for a refill or the exact word when uncached
  assign ar_addr  = req_cached ? {req_addr[31:2+OFF_W], {(OFF_W+2){1'b0}}} : req_addr;
  assign ar_len   = req_cached ? 8'(LINE_WORDS - 1) : 8'd0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= axi_pkg::IC_IDLE;
      req_cached <= 1'b0;
      beat_cnt   <= '0;
    end else begin
      case (state)
        axi_pkg::IC_IDLE: begin
          if (req) begin
            req_cached <= cached;
            if (cached && hit) begin
              state <= axi_pkg::IC_RESP;
            end else begin
              state <= axi_pkg::IC_MISS_ADDR;
            end
          end
        end
        axi_pkg::IC_MISS_ADDR: begin
          if (ar_ready) begin
            state    <= axi_pkg::IC_MISS_DATA;
            beat_cnt <= '0;
          end
        end
        axi_pkg::IC_MISS_DATA: begin
          if (r_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (r_last) begin
              state <= axi_pkg::IC_RESP;
            end
          end
        end
        default: begin
          state <= axi_pkg::IC_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < SETS; i++) begin
        valid[i] <= 1'b0;
      end
    end else if (fill_beat && r_last && req_cached) begin
      valid[fill_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (addr_ok && req) begin
      req_addr <= addr;
      if (cached && hit) begin
        rdata_q <= line_mem[{in_idx, addr[2 +: OFF_W]}];
      end
    end
    if (fill_beat) begin
      if (req_cached) begin
        line_mem[{fill_idx, beat_cnt}] <= r_data;
      end
      // keep the requested word as it streams past
      if (!req_cached || beat_cnt == fill_off) begin
        rdata_q <= r_data;
      end
      if (req_cached && r_last) begin
        tag_mem[fill_idx] <= req_addr[31 -: TAG_W];
      end
    end
  end

  // data_ok only after an accepted hit or the last beat of a read
  a_resp_source: assert property (@(posedge clk) disable iff (!rst_n)
    data_ok |-> $past((addr_ok && req && cached && hit) || (fill_beat && r_last)));

  // refill must be exactly one line long
  a_fill_len: assert property (@(posedge clk) disable iff (!rst_n)
    (fill_beat && req_cached) |-> (r_last == (beat_cnt == OFF_W'(LINE_WORDS - 1))));

endmodule

// File: run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --timing --top-module tb_top -f tb.f > sim.log 2>&1 \
  && ./obj_dir/Vtb_top >> sim.log 2>&1 \
  || echo "Test failures found" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; }
grep -q "All tests passed!" sim.log && echo "PASS" || { echo "FAIL: no pass message"; exit 1; }

// File: tb.f
design/cpu_if_pkg.sv
design/axi_pkg.sv
design/icache.sv
design/data_port.sv
design/axi_arbiter.sv
design/cpu_mem_top.sv
tb/axi_mem_model.sv
tb/tb_top.sv

// File: tb/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model (
  input  logic             clk,
  input  logic             rst_n,
  input  axi_pkg::axi_id_e arid,
  input  logic [31:0]      araddr,
  input  logic [7:0]       arlen,
  input  logic             arvalid,
  output logic             arready,
  output logic [3:0]       rid,
  output logic [31:0]      rdata,
  output logic             rlast,
  output logic             rvalid,
  input  logic             rready,
  input  logic [31:0]      awaddr,
  input  logic             awvalid,
  output logic             awready,
  input  logic [31:0]      wdata,
  input  logic [3:0]       wstrb,
  input  logic             wlast,
  input  logic             wvalid,
  output logic             wready,
  output logic             bvalid,
  input  logic             bready
);

  // sparse storage where untouched words read as the fill pattern
  logic [31:0] mem [logic [31:0]];

  int unsigned ar_count;
  logic [7:0]  last_arlen;
  logic [31:0] last_araddr;
  logic        last_wlast;

  logic             rd_busy;
  axi_pkg::axi_id_e rd_id;
  logic [31:0]      rd_addr;
  logic [7:0]       rd_len;
  logic [7:0]       rd_beat;
  logic             aw_got;
  logic             w_got;
  logic             b_pend;
  logic [31:0]      aw_addr_q;
  logic [31:0]      w_data_q;
  logic [3:0]       w_strb_q;

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [31:0] wa;
    wa = {addr[31:2], 2'b00};
    if (mem.exists(wa)) begin
      return mem[wa];
    end
    return wa ^ 32'h5a5a_0000;
  endfunction

  task automatic apply_write();
    logic [31:0] word;
    word = read_word(aw_addr_q);
    for (int b = 0; b < 4; b++) begin
      if (w_strb_q[b]) begin
        word[b*8 +: 8] = w_data_q[b*8 +: 8];
      end
    end
    mem[{aw_addr_q[31:2], 2'b00}] = word;
  endtask

  task automatic drive_idle();
    arready = 1'b0;
    rvalid  = 1'b0;
    rid     = '0;
    rdata   = '0;
    rlast   = 1'b0;
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
  endtask

  // handshakes are sampled on the rising edge
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ar_count    = 0;
      last_arlen  = '0;
      last_araddr = '0;
      last_wlast  = 1'b0;
      rd_busy     = 1'b0;
      rd_id       = axi_pkg::ID_INST;
      rd_addr     = '0;
      rd_len      = '0;
      rd_beat     = '0;
      aw_got      = 1'b0;
      w_got       = 1'b0;
      b_pend      = 1'b0;
    end else begin
      if (arvalid && arready) begin
        ar_count++;
        last_arlen  = arlen;
        last_araddr = araddr;
        rd_busy     = 1'b1;
        rd_id       = arid;
        rd_addr     = araddr;
        rd_len      = arlen;
        rd_beat     = '0;
      end
      if (rvalid && rready) begin
        if (rlast) begin
          rd_busy = 1'b0;
        end else begin
          rd_beat = rd_beat + 8'd1;
          rd_addr = rd_addr + 32'd4;
        end
      end
      if (awvalid && awready) begin
        aw_got    = 1'b1;
        aw_addr_q = awaddr;
      end
      if (wvalid && wready) begin
        w_got      = 1'b1;
        w_data_q   = wdata;
        w_strb_q   = wstrb;
        last_wlast = wlast;
      end
      if (bvalid && bready) begin
        b_pend = 1'b0;
      end
      if (aw_got && w_got && !b_pend) begin
        apply_write();
        aw_got = 1'b0;
        w_got  = 1'b0;
        b_pend = 1'b1;
      end
    end
  end

  // outputs change on the falling edge with random stalls
  initial begin
    drive_idle();
    forever begin
      @(negedge clk);
      if (!rst_n) begin
        drive_idle();
      end else begin
        arready = !rd_busy && ($urandom_range(0, 3) != 0);
        rvalid  = rd_busy && ($urandom_range(0, 3) != 0);
        rid     = rd_id;
        rdata   = read_word(rd_addr);
        rlast   = (rd_beat == rd_len);
        awready = !aw_got && !b_pend && ($urandom_range(0, 2) != 0);
        wready  = !w_got && !b_pend && ($urandom_range(0, 2) != 0);
        bvalid  = b_pend;
      end
    end
  end

endmodule

// File: tb/tb_top.sv
`timescale 1ns/1ps

module tb_top;

  localparam int LINE_WORDS   = 4;
  localparam int SETS         = 16;
  localparam int ACCEPT_LIMIT = 200;
  localparam int RESP_LIMIT   = 500;
  localparam int RAND_OPS     = 60;

  logic              clk;
  logic              rst_n;
  logic              inst_req;
  logic              inst_cached;
  logic [31:0]       inst_addr;
  logic              inst_addr_ok;
  logic              inst_data_ok;
  logic [31:0]       inst_rdata;
  logic              data_req;
  logic              data_wr;
  cpu_if_pkg::size_e data_size;
  logic [31:0]       data_addr;
  logic [31:0]       data_wdata;
  logic              data_addr_ok;
  logic              data_data_ok;
  logic [31:0]       data_rdata;
  axi_pkg::axi_id_e  arid;
  logic [31:0]       araddr;
  logic [7:0]        arlen;
  logic              arvalid;
  logic              arready;
  logic [3:0]        rid;
  logic [31:0]       rdata;
  logic              rlast;
  logic              rvalid;
  logic              rready;
  logic [31:0]       awaddr;
  logic              awvalid;
  logic              awready;
  logic [31:0]       wdata;
  logic [3:0]        wstrb;
  logic              wlast;
  logic              wvalid;
  logic              wready;
  logic              bvalid;
  logic              bready;

  // completed stores by word address
  logic [31:0] shadow [logic [31:0]];
  logic [31:0] inst_exp[$];
  logic [31:0] data_exp[$];
  logic        data_chk[$];
  logic [31:0] exp_inst;
  logic [31:0] exp_data;
  logic        chk_data;
  string       test_name;

  cpu_mem_top #(
    .LINE_WORDS (LINE_WORDS),
    .SETS       (SETS)
  ) i_cpu_mem_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_req     (inst_req),
    .inst_cached  (inst_cached),
    .inst_addr    (inst_addr),
    .inst_addr_ok (inst_addr_ok),
    .inst_data_ok (inst_data_ok),
    .inst_rdata   (inst_rdata),
    .data_req     (data_req),
    .data_wr      (data_wr),
    .data_size    (data_size),
    .data_addr    (data_addr),
    .data_wdata   (data_wdata),
    .data_addr_ok (data_addr_ok),
    .data_data_ok (data_data_ok),
    .data_rdata   (data_rdata),
    .arid         (arid),
    .araddr       (araddr),
    .arlen        (arlen),
    .arvalid      (arvalid),
    .arready      (arready),
    .rid          (rid),
    .rdata        (rdata),
    .rlast        (rlast),
    .rvalid       (rvalid),
    .rready       (rready),
    .awaddr       (awaddr),
    .awvalid      (awvalid),
    .awready      (awready),
    .wdata        (wdata),
    .wstrb        (wstrb),
    .wlast        (wlast),
    .wvalid       (wvalid),
    .wready       (wready),
    .bvalid       (bvalid),
    .bready       (bready)
  );

  axi_mem_model i_axi_mem_model (
    .clk     (clk),
    .rst_n   (rst_n),
    .arid    (arid),
    .araddr  (araddr),
    .arlen   (arlen),
    .arvalid (arvalid),
    .arready (arready),
    .rid     (rid),
    .rdata   (rdata),
    .rlast   (rlast),
    .rvalid  (rvalid),
    .rready  (rready),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wlast   (wlast),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // last completed store or else the memory fill pattern
  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    logic [31:0] wa;
    wa = {addr[31:2], 2'b00};
    if (shadow.exists(wa)) begin
      return shadow[wa];
    end
    return wa ^ 32'h5a5a_0000;
  endfunction

  // byte-lane merge of a store into the shadow word
  function automatic void record_store(input logic [31:0] addr, input cpu_if_pkg::size_e size,
                                       input logic [31:0] value);
    logic [31:0] word;
    word = expected_word(addr);
    case (size)
      cpu_if_pkg::SIZE_BYTE: word[addr[1:0]*8 +: 8] = value[7:0];
      cpu_if_pkg::SIZE_HALF: word[addr[1]*16 +: 16] = value[15:0];
      default:               word = value;
    endcase
    shadow[{addr[31:2], 2'b00}] = word;
  endfunction

  task automatic stop_on_failure();
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_timeout(input string what);
    $display("timeout in %s: %s never arrived", test_name, what);
    stop_on_failure();
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s: %s expected %h actual %h", test_name, what, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic check_last_ar(input int unsigned count, input int len, input logic [31:0] addr);
    check_value("ar count", count, i_axi_mem_model.ar_count);
    check_value("arlen", len, 32'(i_axi_mem_model.last_arlen));
    check_value("araddr", addr, i_axi_mem_model.last_araddr);
  endtask

  // starts and ends on a falling edge
  // lat counts cycles from acceptance to data_ok
  task automatic fetch(input logic [31:0] addr, input logic cached, output int lat);
    int n;
    inst_exp.push_back(expected_word(addr));
    inst_req    = 1'b1;
    inst_cached = cached;
    inst_addr   = addr;
    n = 0;
    @(posedge clk);
    while (!inst_addr_ok) begin
      n++;
      if (n > ACCEPT_LIMIT) report_timeout("inst_addr_ok");
      @(posedge clk);
    end
    @(negedge clk);
    inst_req = 1'b0;
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
      if (lat > RESP_LIMIT) report_timeout("inst_data_ok");
    end while (!inst_data_ok);
    @(negedge clk);
  endtask

  task automatic data_access(input logic wr, input cpu_if_pkg::size_e size,
                             input logic [31:0] addr, input logic [31:0] value);
    int n;
    data_chk.push_back(!wr);
    data_exp.push_back(expected_word(addr));
    data_req   = 1'b1;
    data_wr    = wr;
    data_size  = size;
    data_addr  = addr;
    data_wdata = value;
    n = 0;
    @(posedge clk);
    while (!data_addr_ok) begin
      n++;
      if (n > ACCEPT_LIMIT) report_timeout("data_addr_ok");
      @(posedge clk);
    end
    @(negedge clk);
    data_req = 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > RESP_LIMIT) report_timeout("data_data_ok");
    end while (!data_data_ok);
    if (wr) begin
      record_store(addr, size, value);
    end
    @(negedge clk);
    if (wr) begin
      check_value("wlast", 1, 32'(i_axi_mem_model.last_wlast));
    end
  endtask

  task automatic random_data_op();
    logic [31:0]       addr;
    logic              wr;
    cpu_if_pkg::size_e size;
    addr = {24'h100001, 8'($urandom)};
    wr   = 1'($urandom_range(0, 1));
    size = cpu_if_pkg::size_e'($urandom_range(0, 2));
    if (!wr) begin
      size = cpu_if_pkg::SIZE_WORD;
    end
    if (size == cpu_if_pkg::SIZE_HALF) begin
      addr[0] = 1'b0;
    end else if (size == cpu_if_pkg::SIZE_WORD) begin
      addr[1:0] = 2'b00;
    end
    data_access(wr, size, addr, $urandom);
  endtask

  // response checker for both ports
  always @(posedge clk) begin
    if (rst_n && inst_data_ok) begin
      if (inst_exp.size() == 0) begin
        $display("inst_data_ok pulsed with no fetch outstanding");
        stop_on_failure();
      end else begin
        exp_inst = inst_exp.pop_front();
        check_value("fetch data", exp_inst, inst_rdata);
      end
    end
    if (rst_n && data_data_ok) begin
      if (data_exp.size() == 0) begin
        $display("data_data_ok pulsed with no access outstanding");
        stop_on_failure();
      end else begin
        exp_data = data_exp.pop_front();
        chk_data = data_chk.pop_front();
        if (chk_data) begin
          check_value("load data", exp_data, data_rdata);
        end
      end
    end
  end

  initial begin
    int          lat;
    int          lat_r;
    int          i;
    int unsigned ar_before;
    void'($urandom(32'hb50a9d5e));
    rst_n         = 1'b0;
    inst_req      = 1'b0;
    inst_cached   = 1'b0;
    inst_addr     = '0;
    data_req      = 1'b0;
    data_wr       = 1'b0;
    data_size     = cpu_if_pkg::SIZE_WORD;
    data_addr     = '0;
    data_wdata    = '0;
    test_name     = "reset";
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("arvalid", 0, 32'(arvalid));
    check_value("awvalid", 0, 32'(awvalid));
    check_value("wvalid", 0, 32'(wvalid));
    check_value("rready", 0, 32'(rready));
    check_value("bready", 0, 32'(bready));
    check_value("inst_data_ok", 0, 32'(inst_data_ok));
    check_value("data_data_ok", 0, 32'(data_data_ok));
    check_value("inst_addr_ok", 1, 32'(inst_addr_ok));
    check_value("data_addr_ok", 1, 32'(data_addr_ok));

    test_name = "store sizes";
    data_access(1'b1, cpu_if_pkg::SIZE_WORD, 32'h1000_0000, 32'h1122_3344);
    data_access(1'b1, cpu_if_pkg::SIZE_BYTE, 32'h1000_0001, 32'hffff_ffab);
    data_access(1'b1, cpu_if_pkg::SIZE_HALF, 32'h1000_0002, 32'h5555_beef);
    data_access(1'b1, cpu_if_pkg::SIZE_BYTE, 32'h1000_0007, 32'h0000_00c3);
    data_access(1'b1, cpu_if_pkg::SIZE_HALF, 32'h1000_0008, 32'h9999_7e81);
    data_access(1'b1, cpu_if_pkg::SIZE_BYTE, 32'h1000_000e, 32'h0000_0042);
    for (i = 0; i < 4; i++) begin
      data_access(1'b0, cpu_if_pkg::SIZE_WORD, 32'h1000_0000 + 32'(4 * i), 32'h0);
    end

    test_name = "icache miss";
    ar_before = i_axi_mem_model.ar_count;
    fetch(32'h0000_2018, 1'b1, lat);
    check_last_ar(ar_before + 1, LINE_WORDS - 1, 32'h0000_2010);
    test_name = "icache hit";
    for (i = 0; i < LINE_WORDS; i++) begin
      fetch(32'h0000_2010 + 32'(4 * i), 1'b1, lat);
      check_value("hit latency", 1, 32'(lat));
    end
    check_value("ar count", ar_before + 1, i_axi_mem_model.ar_count);

    test_name = "icache eviction";
    fetch(32'h0000_2018 + 32'(SETS * LINE_WORDS * 4), 1'b1, lat);
    check_value("ar count", ar_before + 2, i_axi_mem_model.ar_count);
    fetch(32'h0000_2018, 1'b1, lat);
    check_last_ar(ar_before + 3, LINE_WORDS - 1, 32'h0000_2010);

    test_name = "uncached fetch";
    for (i = 0; i < 3; i++) begin
      ar_before = i_axi_mem_model.ar_count;
      fetch(32'h0000_3004, 1'b0, lat);
      check_last_ar(ar_before + 1, 0, 32'h0000_3004);
    end

    test_name = "random traffic";
    fork
      begin
        repeat (RAND_OPS) begin
          fetch(32'h0000_4000 + 32'(4 * $urandom_range(0, 127)), $urandom_range(0, 3) != 0,
                lat_r);
        end
      end
      begin
        repeat (RAND_OPS) begin
          random_data_op();
        end
      end
    join
    // no stray data_ok after the traffic stops
    repeat (20) @(negedge clk);

    $display("All tests passed!");
    $finish;
  end

endmodule
